/* rtl/vlane_pkg.sv */
`default_nettype none

package vlane_pkg;

  // element and shift widths
  typedef logic [31:0] word_t;   // one vector element
  typedef logic [4:0]  shamt_t;  // low bits of vs2 used as shift count

  // functional unit select, codes 2 and 3 are reserved (illegal op)
  typedef enum logic [1:0] {
    VFU_ARITH = 2'd0,
    VFU_MUL   = 2'd1,
    VFU_RSVD2 = 2'd2,
    VFU_RSVD3 = 2'd3
  } vfu_e;

  // arith unit opcodes, mult unit does not look at these
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_SRA = 3'd7
  } arith_op_e;

  // one element operation as issued to the lane
  typedef struct packed {
    vfu_e      fu;
    arith_op_e op;
    word_t     vs1;
    word_t     vs2;
  } lane_issue_t;

  // what a unit hands back, done is a single-cycle pulse
  typedef struct packed {
    logic  done;
    logic  exception;
    word_t wdata;
  } unit_result_t;

  // multiplier bits retired per cycle, must divide 32
  localparam int unsigned MUL_BITS_DEFAULT = 2;

endpackage

`default_nettype wire

/* rtl/arith_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
  input  wire logic                   CLK,
  input  wire logic                   rst,
  input  wire logic                   start,
  input  wire vlane_pkg::lane_issue_t issue,
  output vlane_pkg::unit_result_t     res
);

  import vlane_pkg::*;

  word_t  a;
  word_t  b;
  shamt_t sh;       // shift count from vs2
  word_t  sum;
  word_t  diff;
  word_t  alu_out;
  logic   ovf;      // signed overflow, add/sub only

  logic   done_q;
  logic   exc_q;
  word_t  wdata_q;

  assign a    = issue.vs1;
  assign b    = issue.vs2;
  assign sh   = issue.vs2[4:0];
  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    alu_out = '0;
    ovf     = 1'b0;
    case (issue.op)
      OP_ADD: begin
        alu_out = sum;
        ovf     = (a[31] == b[31]) && (sum[31] != a[31]); // same signs in, flip out
      end
      OP_SUB: begin
        alu_out = diff;
        ovf     = (a[31] != b[31]) && (diff[31] != a[31]); // opposite signs in
      end
      OP_AND: alu_out = a & b;
      OP_OR:  alu_out = a | b;
      OP_XOR: alu_out = a ^ b;
      OP_SLL: alu_out = a << sh;
      OP_SRL: alu_out = a >> sh;
      OP_SRA: alu_out = word_t'($signed(a) >>> sh); // sign fill
      default: begin
        alu_out = '0;
        ovf     = 1'b0;
      end
    endcase
  end

  // done pulse, one cycle after start
  always_ff @(posedge CLK) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= start;
    end
  end

  // result payload, only loaded on start
  always_ff @(posedge CLK) begin
    if (start) begin
      wdata_q <= alu_out;
      exc_q   <= ovf;
    end
  end

  assign res.done      = done_q;
  assign res.exception = exc_q;
  assign res.wdata     = wdata_q;

endmodule

`default_nettype wire

/* rtl/mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
  parameter int unsigned MUL_BITS = vlane_pkg::MUL_BITS_DEFAULT
) (
  input  wire logic                   CLK,
  input  wire logic                   rst,
  input  wire logic                   start,
  input  wire vlane_pkg::lane_issue_t issue,
  output vlane_pkg::unit_result_t     res,
  output logic                        busy
);

  import vlane_pkg::*;

  localparam int unsigned STEPS = 32 / MUL_BITS;   // iterations per multiply
  localparam int unsigned CNT_W = $clog2(STEPS + 1);

  typedef enum logic {
    MU_IDLE = 1'b0,
    MU_RUN  = 1'b1
  } mu_state_e;

  mu_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;    // steps left
  logic             done_q;

  word_t mcand_q;   // shifted left each step
  word_t mplier_q;  // shifted right as low MUL_BITS are used
  word_t acc_q;     // low 32 bits of running product
  word_t pp;        // partial product for this step

  // shift-add over the low MUL_BITS multiplier bits
  always_comb begin
    pp = '0;
    for (int j = 0; j < MUL_BITS; j++) begin
      if (mplier_q[j]) pp = pp + (mcand_q << j);
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state_q <= MU_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;  // pulse
      case (state_q)
        MU_IDLE: begin
          if (start) begin
            state_q <= MU_RUN;
            cnt_q   <= CNT_W'(STEPS);
          end
        end
        MU_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin  // last step
            state_q <= MU_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= MU_IDLE;
      endcase
    end
  end

  // operand shifters and accumulator
  always_ff @(posedge CLK) begin
    if (state_q == MU_IDLE && start) begin
      mcand_q  <= issue.vs1;
      mplier_q <= issue.vs2;
      acc_q    <= '0;
    end else if (state_q == MU_RUN) begin
      acc_q    <= acc_q + pp;
      mcand_q  <= mcand_q << MUL_BITS;
      mplier_q <= mplier_q >> MUL_BITS;
    end
  end

  assign busy          = (state_q == MU_RUN);
  assign res.done      = done_q;
  assign res.exception = 1'b0;   // mult never traps
  assign res.wdata     = acc_q;  // same low word for signed and unsigned

endmodule

`default_nettype wire

/* rtl/lane_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_ctrl (
  input  wire logic                    CLK,
  input  wire logic                    rst,
  input  wire logic                    start,
  input  wire vlane_pkg::lane_issue_t  issue,
  input  wire vlane_pkg::unit_result_t au_res,
  input  wire vlane_pkg::unit_result_t mu_res,
  input  wire logic                    mu_busy,
  output logic                         au_start,
  output logic                         mu_start,
  output vlane_pkg::lane_issue_t       unit_issue,  // operands held for the units
  output logic                         busy,
  output logic                         lane_done,
  output logic                         lane_exception,
  output vlane_pkg::word_t             lane_result
);

  import vlane_pkg::*;

  logic         accept;       // start while idle
  logic         outstanding;  // op in flight
  logic         ill_start;    // reserved fu accepted
  logic         ill_pend;     // illegal op waiting to complete
  logic         unit_done;
  unit_result_t sel_res;

  assign accept = start & ~busy;  // starts while busy are dropped
  assign busy   = outstanding | mu_busy;

  // pick whichever unit finished
  always_comb begin
    sel_res = '0;
    if (au_res.done) begin
      sel_res = au_res;
    end else if (mu_res.done) begin
      sel_res = mu_res;
    end else if (ill_pend) begin
      sel_res.done      = 1'b1;
      sel_res.exception = 1'b1;  // illegal op, result stays zero
    end
  end

  assign unit_done = sel_res.done;

  always_ff @(posedge CLK) begin
    if (rst) begin
      au_start       <= 1'b0;
      mu_start       <= 1'b0;
      ill_start      <= 1'b0;
      ill_pend       <= 1'b0;
      outstanding    <= 1'b0;
      lane_done      <= 1'b0;
      lane_exception <= 1'b0;
      lane_result    <= '0;
    end else begin
      au_start  <= accept && (issue.fu == VFU_ARITH);
      mu_start  <= accept && (issue.fu == VFU_MUL);
      ill_start <= accept && (issue.fu == VFU_RSVD2 || issue.fu == VFU_RSVD3);
      ill_pend  <= ill_start;  // matches arith latency
      lane_done <= unit_done;
      if (unit_done) begin
        lane_exception <= sel_res.exception;
        lane_result    <= sel_res.wdata;
      end
      if (accept) outstanding <= 1'b1;
      else if (unit_done) outstanding <= 1'b0;  // low in the lane_done cycle
    end
  end

  // operand capture
  always_ff @(posedge CLK) begin
    if (accept) unit_issue <= issue;
  end

endmodule

`default_nettype wire

/* rtl/vector_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_lane #(
  parameter int unsigned MUL_BITS = vlane_pkg::MUL_BITS_DEFAULT
) (
  input  wire logic                   CLK,
  input  wire logic                   rst,
  input  wire logic                   start,          // one-cycle issue strobe
  input  wire vlane_pkg::lane_issue_t issue,
  output logic                        busy,           // level
  output logic                        lane_done,      // one-cycle pulse
  output logic                        lane_exception, // qualified by lane_done
  output vlane_pkg::word_t            lane_result
);

  import vlane_pkg::*;

  logic         au_start;   // registered strobes from lane_ctrl
  logic         mu_start;
  lane_issue_t  unit_issue; // issue captured at acceptance
  unit_result_t au_res;
  unit_result_t mu_res;
  logic         mu_busy;

  arith_unit arith_unit_inst (
    .CLK   (CLK),
    .rst   (rst),
    .start (au_start),
    .issue (unit_issue),
    .res   (au_res)
  );

  mult_unit #(
    .MUL_BITS (MUL_BITS)
  ) mult_unit_inst (
    .CLK   (CLK),
    .rst   (rst),
    .start (mu_start),
    .issue (unit_issue),
    .res   (mu_res),
    .busy  (mu_busy)
  );

  lane_ctrl lane_ctrl_inst (
    .CLK            (CLK),
    .rst            (rst),
    .start          (start),
    .issue          (issue),
    .au_res         (au_res),
    .mu_res         (mu_res),
    .mu_busy        (mu_busy),
    .au_start       (au_start),
    .mu_start       (mu_start),
    .unit_issue     (unit_issue),
    .busy           (busy),
    .lane_done      (lane_done),
    .lane_exception (lane_exception),
    .lane_result    (lane_result)
  );

endmodule

`default_nettype wire

/* test/vector_lane_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_lane_chk (
  input wire logic CLK,
  input wire logic rst,
  input wire logic start,
  input wire logic busy,
  input wire logic lane_done,
  input wire logic au_start,  // internal strobes of the lane
  input wire logic mu_start
);

  int fail_count = 0;  // assertion failures so far

  done_pulse: assert property (@(posedge CLK) disable iff (rst) lane_done |=> !lane_done)
    else begin
      $error("lane_done held longer than one cycle");
      fail_count++;
    end

  // completion only from an op in flight
  done_from_busy: assert property (@(posedge CLK) disable iff (rst) lane_done |-> $past(busy))
    else begin
      $error("lane_done without busy the cycle before");
      fail_count++;
    end

  // busy only rises after an issue
  busy_needs_start: assert property (@(posedge CLK) disable iff (rst) $rose(busy) |-> $past(start))
    else begin
      $error("busy rose without a start");
      fail_count++;
    end

  // unit starts are one-hot and only follow an issue accepted while idle
  one_unit: assert property (@(posedge CLK) disable iff (rst)
      (au_start || mu_start) |-> !(au_start && mu_start) && $past(start && !busy))
    else begin
      $error("unit start without an accepted issue or both unit starts high");
      fail_count++;
    end

endmodule

bind vector_lane vector_lane_chk vector_lane_chk_inst (
  .CLK       (CLK),
  .rst       (rst),
  .start     (start),
  .busy      (busy),
  .lane_done (lane_done),
  .au_start  (au_start),
  .mu_start  (mu_start)
);

`default_nettype wire

/* test/tb_vector_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_lane;

  import vlane_pkg::*;

  localparam int unsigned MUL_BITS = MUL_BITS_DEFAULT;
  localparam int MUL_LAT  = 32 / MUL_BITS + 2;  // start edge to lane_done edge
  localparam int TIMEOUT  = 100;                // cycles per wait

  logic        CLK;
  logic        rst;
  logic        start;
  lane_issue_t issue;
  logic        busy;
  logic        lane_done;
  logic        lane_exception;
  word_t       lane_result;

  integer seed = 68;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int bad_tests = 0;
  int test_err0 = 0;  // error count when the current test began

  vector_lane #(.MUL_BITS(MUL_BITS)) vector_lane_inst (
    .CLK            (CLK),
    .rst            (rst),
    .start          (start),
    .issue          (issue),
    .busy           (busy),
    .lane_done      (lane_done),
    .lane_exception (lane_exception),
    .lane_result    (lane_result)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    #200000;  // whole run guard
    $display("run did not finish in time, stopping");
    $display("Simulation failed");
    $finish;
  end

  task automatic expect_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // reference for one element op
  task automatic model_op(input lane_issue_t iss, output word_t r, output logic e);
    longint wide;  // exact signed sum or difference
    r = '0;
    e = 1'b1;      // reserved fu traps with zero result
    if (iss.fu == VFU_MUL) begin
      r = iss.vs1 * iss.vs2;  // low word of product
      e = 1'b0;
    end else if (iss.fu == VFU_ARITH) begin
      e = 1'b0;
      case (iss.op)
        OP_ADD, OP_SUB: begin
          if (iss.op == OP_ADD) wide = longint'($signed(iss.vs1)) + longint'($signed(iss.vs2));
          else wide = longint'($signed(iss.vs1)) - longint'($signed(iss.vs2));
          r = wide[31:0];
          e = (wide != longint'($signed(wide[31:0])));  // does not fit in 32 signed bits
        end
        OP_AND: r = iss.vs1 & iss.vs2;
        OP_OR:  r = iss.vs1 | iss.vs2;
        OP_XOR: r = iss.vs1 ^ iss.vs2;
        OP_SLL: r = iss.vs1 << iss.vs2[4:0];
        OP_SRL: r = iss.vs1 >> iss.vs2[4:0];
        default: begin
          wide = longint'($signed(iss.vs1)) >>> iss.vs2[4:0];  // sign fill
          r = wide[31:0];
        end
      endcase
    end
  endtask

  function automatic word_t pick_operand();
    word_t r;
    r = $random(seed);
    case (r[31:29])
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return {1'b1, r[30:0]};  // negative
      default: return r;
    endcase
  endfunction

  function automatic lane_issue_t rand_issue(input vfu_e fu);
    lane_issue_t iss;
    int r;
    r = $random(seed);
    iss.fu  = fu;
    iss.op  = arith_op_e'(r[2:0]);
    iss.vs1 = pick_operand();
    iss.vs2 = pick_operand();
    return iss;
  endfunction

  task automatic idle_gap();
    int r;
    r = $random(seed);
    repeat (r[1:0]) @(negedge CLK);  // zero means issue in the lane_done cycle
  endtask

  // issue at a falling edge and wait for lane_done with an optional start mid-flight
  task automatic run_op(input lane_issue_t iss, input int exp_lat, input int drop_at,
                        input lane_issue_t alt);
    word_t exp_r;
    logic  exp_e;
    int    lat;
    model_op(iss, exp_r, exp_e);
    issue = iss;
    start = 1'b1;
    @(negedge CLK);
    lat = 0;
    while (!lane_done && lat < TIMEOUT) begin
      expect_val("busy before lane_done", busy, 1);
      start = (lat == drop_at);  // lane is busy so this must be ignored
      issue = alt;
      @(negedge CLK);
      lat++;
    end
    start = 1'b0;
    if (!lane_done) begin
      $display("lane_done did not arrive within %0d cycles at %0t", TIMEOUT, $time);
      errors++;
    end
    expect_val("latency", lat, exp_lat);
    expect_val("lane_result", lane_result, exp_r);
    expect_val("lane_exception", lane_exception, exp_e);
    expect_val("busy in lane_done cycle", busy, 0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) $display("test %s: ok", name);
    else begin
      bad_tests++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    lane_issue_t iss;
    lane_issue_t alt;
    int r;
    int extra;
    rst   = 1'b1;
    start = 1'b0;
    issue = '0;
    repeat (16) @(negedge CLK);
    rst = 1'b0;
    repeat (2) begin
      @(negedge CLK);
      expect_val("busy after reset", busy, 0);
      expect_val("lane_done after reset", lane_done, 0);
      expect_val("lane_exception after reset", lane_exception, 0);
      expect_val("lane_result after reset", lane_result, 0);
    end
    end_test("reset");
    for (int i = 0; i < 40; i++) begin
      iss = rand_issue(VFU_ARITH);
      if (i < 8) iss.op = arith_op_e'(i[2:0]);  // every opcode at least once
      run_op(iss, 2, -1, iss);
      idle_gap();
    end
    end_test("arith");
    for (int i = 0; i < 24; i++) begin
      iss = rand_issue(VFU_MUL);
      run_op(iss, MUL_LAT, -1, iss);
      idle_gap();
    end
    end_test("mul");
    for (int i = 0; i < 8; i++) begin
      iss = rand_issue(i[0] ? VFU_RSVD3 : VFU_RSVD2);
      run_op(iss, 2, -1, iss);
      idle_gap();
    end
    end_test("reserved");
    for (int i = 0; i < 4; i++) begin
      iss = rand_issue(VFU_MUL);
      alt = rand_issue(i[0] ? VFU_ARITH : VFU_MUL);
      r = $random(seed);
      run_op(iss, MUL_LAT, 1 + (r[7:0] % (MUL_LAT - 2)), alt);
      extra = 0;
      repeat (2 * MUL_LAT) begin
        @(negedge CLK);
        if (lane_done) extra++;
      end
      expect_val("lane_done count after dropped start", extra, 0);
    end
    end_test("dropped start");
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      iss = rand_issue(r[0] ? VFU_MUL : VFU_ARITH);
      run_op(iss, (iss.fu == VFU_MUL) ? MUL_LAT : 2, -1, iss);  // no gap between ops
    end
    @(negedge CLK);
    end_test("issue on lane_done");
    errors += vector_lane_inst.vector_lane_chk_inst.fail_count;  // bound checker failures
    end_test("protocol assertions");
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests, bad_tests, checks, errors);
    if (errors == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vector_lane.f */
rtl/vlane_pkg.sv
rtl/arith_unit.sv
rtl/mult_unit.sv
rtl/lane_ctrl.sv
rtl/vector_lane.sv
test/vector_lane_chk.sv
test/tb_vector_lane.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_lane \
  -f vector_lane.f -o sim_vector_lane \
  && ./obj_dir/sim_vector_lane | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
  && echo "run.sh: pass line found" \
  || { echo "run.sh: pass line missing"; exit 1; }
